// ==== common/clip_pkg.sv ====
`default_nettype none

package clip_pkg;

  // one ieee single-precision value
  typedef logic [31:0] fp32_t;

  // surface material code, all 12 bits travel with the vertex
  typedef logic [11:0] material_t;

  // slot of a vertex inside its triangle
  typedef logic [1:0] vidx_t;

  // vertices per triangle
  localparam int TRI_VERTS = 3;

  // triangle slot values
  localparam vidx_t VIDX_FIRST = 2'd0;
  localparam vidx_t VIDX_MID = 2'd1;
  localparam vidx_t VIDX_LAST = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/fp32_bound.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp32_bound (
  input wire clk_in,
  input wire rst_in,
  input wire valid_in,
  input wire clip_pkg::fp32_t a_in,
  input wire clip_pkg::fp32_t b_in,
  output logic valid_out,
  output logic inside_out
);

  logic a_nan;
  logic b_nan;
  logic b_nonneg;
  logic mag_ok;

  // exponent all ones with a non-zero mantissa
  assign a_nan = (a_in[30:23] == 8'hff) && (a_in[22:0] != 23'd0);
  assign b_nan = (b_in[30:23] == 8'hff) && (b_in[22:0] != 23'd0);

  // minus zero counts as zero here
  assign b_nonneg = !b_in[31] || (b_in[30:0] == 31'd0);

  // sign-magnitude format, so magnitudes order like unsigned ints
  assign mag_ok = (a_in[30:0] <= b_in[30:0]);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  always_ff @(posedge clk_in) begin
    inside_out <= b_nonneg && !a_nan && !b_nan && mag_ok;
  end

endmodule

`default_nettype wire

// ==== hdl/vertex_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_intake (
  input wire clk_in,
  input wire rst_in,
  input wire in_req,
  output logic in_ack,
  input wire clip_pkg::fp32_t pos_x_in,
  input wire clip_pkg::fp32_t pos_y_in,
  input wire clip_pkg::fp32_t pos_z_in,
  input wire clip_pkg::fp32_t pos_w_in,
  input wire clip_pkg::fp32_t norm_x_in,
  input wire clip_pkg::fp32_t norm_y_in,
  input wire clip_pkg::fp32_t norm_z_in,
  input wire clip_pkg::material_t material_in,
  input wire room,
  output logic vtx_valid,
  output clip_pkg::fp32_t pos_x,
  output clip_pkg::fp32_t pos_y,
  output clip_pkg::fp32_t pos_z,
  output clip_pkg::fp32_t pos_w,
  output clip_pkg::fp32_t norm_x,
  output clip_pkg::fp32_t norm_y,
  output clip_pkg::fp32_t norm_z,
  output clip_pkg::material_t material
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_HOLD_ACK,
    S_WAIT_RELEASE
  } intake_state_t;

  intake_state_t state;
  logic take;

  // accept only while the queue can still hold a whole triangle
  assign take = (state == S_IDLE) && in_req && room;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= S_IDLE;
      in_ack <= 1'b0;
      vtx_valid <= 1'b0;
    end else begin
      vtx_valid <= take;
      case (state)
        S_IDLE: begin
          if (take) begin
            in_ack <= 1'b1;
            state <= S_HOLD_ACK;
          end
        end
        S_HOLD_ACK: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state <= S_WAIT_RELEASE;
          end
        end
        // one guard cycle so the sender sees ack low first
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // sender holds data steady while req is high
  always_ff @(posedge clk_in) begin
    if (take) begin
      pos_x <= pos_x_in;
      pos_y <= pos_y_in;
      pos_z <= pos_z_in;
      pos_w <= pos_w_in;
      norm_x <= norm_x_in;
      norm_y <= norm_y_in;
      norm_z <= norm_z_in;
      material <= material_in;
    end
  end

endmodule

`default_nettype wire

// ==== clip/triangle_clip.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_clip (
  input wire clk_in,
  input wire rst_in,
  input wire vtx_valid,
  input wire clip_pkg::fp32_t pos_x,
  input wire clip_pkg::fp32_t pos_y,
  input wire clip_pkg::fp32_t pos_z,
  input wire clip_pkg::fp32_t pos_w,
  input wire clip_pkg::fp32_t norm_x,
  input wire clip_pkg::fp32_t norm_y,
  input wire clip_pkg::fp32_t norm_z,
  input wire clip_pkg::material_t material,
  output logic emit_valid,
  output clip_pkg::fp32_t emit_pos_x,
  output clip_pkg::fp32_t emit_pos_y,
  output clip_pkg::fp32_t emit_pos_z,
  output clip_pkg::fp32_t emit_pos_w,
  output clip_pkg::fp32_t emit_norm_x,
  output clip_pkg::fp32_t emit_norm_y,
  output clip_pkg::fp32_t emit_norm_z,
  output clip_pkg::material_t emit_material
);

  import clip_pkg::*;

  fp32_t coord [3];
  logic [2:0] bound_valid;
  logic [2:0] bound_inside;

  assign coord[0] = pos_x;
  assign coord[1] = pos_y;
  assign coord[2] = pos_z;

  // x, y, z each checked against [-w, w]
  for (genvar i = 0; i < 3; i++) begin : g_bound
    fp32_bound u_bound (
      .clk_in,
      .rst_in,
      .valid_in(vtx_valid),
      .a_in(coord[i]),
      .b_in(pos_w),
      .valid_out(bound_valid[i]),
      .inside_out(bound_inside[i])
    );
  end

  // vertex delayed to line up with the bound results
  fp32_t q_pos_x, q_pos_y, q_pos_z, q_pos_w;
  fp32_t q_norm_x, q_norm_y, q_norm_z;
  material_t q_material;

  always_ff @(posedge clk_in) begin
    q_pos_x <= pos_x;
    q_pos_y <= pos_y;
    q_pos_z <= pos_z;
    q_pos_w <= pos_w;
    q_norm_x <= norm_x;
    q_norm_y <= norm_y;
    q_norm_z <= norm_z;
    q_material <= material;
  end

  fp32_t buf_pos_x [TRI_VERTS];
  fp32_t buf_pos_y [TRI_VERTS];
  fp32_t buf_pos_z [TRI_VERTS];
  fp32_t buf_pos_w [TRI_VERTS];
  fp32_t buf_norm_x [TRI_VERTS];
  fp32_t buf_norm_y [TRI_VERTS];
  fp32_t buf_norm_z [TRI_VERTS];
  material_t buf_material [TRI_VERTS];

  vidx_t vidx;
  vidx_t emit_next;
  vidx_t emit_sel;
  logic tri_inside;
  logic bound_done;
  logic vtx_inside;
  logic start;
  logic emit_busy;
  logic emit_load;

  assign bound_done = &bound_valid;
  assign vtx_inside = &bound_inside;

  // last vertex checked and nothing outside so far
  assign start = bound_done && (vidx == VIDX_LAST) && tri_inside && vtx_inside;
  assign emit_load = start || emit_busy;
  assign emit_sel = start ? VIDX_FIRST : emit_next;

  always_ff @(posedge clk_in) begin
    if (bound_done) begin
      buf_pos_x[vidx] <= q_pos_x;
      buf_pos_y[vidx] <= q_pos_y;
      buf_pos_z[vidx] <= q_pos_z;
      buf_pos_w[vidx] <= q_pos_w;
      buf_norm_x[vidx] <= q_norm_x;
      buf_norm_y[vidx] <= q_norm_y;
      buf_norm_z[vidx] <= q_norm_z;
      buf_material[vidx] <= q_material;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      vidx <= VIDX_FIRST;
      tri_inside <= 1'b1;
      emit_busy <= 1'b0;
      emit_next <= VIDX_FIRST;
      emit_valid <= 1'b0;
    end else begin
      if (bound_done) begin
        if (vidx == VIDX_LAST) begin
          vidx <= VIDX_FIRST;
          tri_inside <= 1'b1;
        end else begin
          vidx <= vidx + 2'd1;
          tri_inside <= tri_inside && vtx_inside;
        end
      end
      emit_valid <= emit_load;
      // vertex 0 goes out with start, then 1 and 2 back to back
      if (start) begin
        emit_busy <= 1'b1;
        emit_next <= VIDX_MID;
      end else if (emit_busy) begin
        if (emit_next == VIDX_LAST) begin
          emit_busy <= 1'b0;
        end else begin
          emit_next <= emit_next + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (emit_load) begin
      emit_pos_x <= buf_pos_x[emit_sel];
      emit_pos_y <= buf_pos_y[emit_sel];
      emit_pos_z <= buf_pos_z[emit_sel];
      emit_pos_w <= buf_pos_w[emit_sel];
      emit_norm_x <= buf_norm_x[emit_sel];
      emit_norm_y <= buf_norm_y[emit_sel];
      emit_norm_z <= buf_norm_z[emit_sel];
      emit_material <= buf_material[emit_sel];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vertex_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input wire clk_in,
  input wire rst_in,
  input wire emit_valid,
  input wire clip_pkg::fp32_t emit_pos_x,
  input wire clip_pkg::fp32_t emit_pos_y,
  input wire clip_pkg::fp32_t emit_pos_z,
  input wire clip_pkg::fp32_t emit_pos_w,
  input wire clip_pkg::fp32_t emit_norm_x,
  input wire clip_pkg::fp32_t emit_norm_y,
  input wire clip_pkg::fp32_t emit_norm_z,
  input wire clip_pkg::material_t emit_material,
  output logic room,
  output logic out_req,
  input wire out_ack,
  output clip_pkg::fp32_t pos_x_out,
  output clip_pkg::fp32_t pos_y_out,
  output clip_pkg::fp32_t pos_z_out,
  output clip_pkg::fp32_t pos_w_out,
  output clip_pkg::fp32_t norm_x_out,
  output clip_pkg::fp32_t norm_y_out,
  output clip_pkg::fp32_t norm_z_out,
  output clip_pkg::material_t material_out
);

  import clip_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  // highest occupancy that still leaves room for a whole triangle
  localparam logic [PTR_W:0] ROOM_MAX = (PTR_W + 1)'(QUEUE_DEPTH - TRI_VERTS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_HOLD_REQ,
    S_WAIT_RELEASE
  } send_state_t;

  fp32_t mem_pos_x [QUEUE_DEPTH];
  fp32_t mem_pos_y [QUEUE_DEPTH];
  fp32_t mem_pos_z [QUEUE_DEPTH];
  fp32_t mem_pos_w [QUEUE_DEPTH];
  fp32_t mem_norm_x [QUEUE_DEPTH];
  fp32_t mem_norm_y [QUEUE_DEPTH];
  fp32_t mem_norm_z [QUEUE_DEPTH];
  material_t mem_material [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;
  send_state_t state;
  logic pop;

  assign room = (count <= ROOM_MAX);
  assign pop = (state == S_HOLD_REQ) && out_ack;

  always_ff @(posedge clk_in) begin
    if (emit_valid) begin
      mem_pos_x[wr_ptr] <= emit_pos_x;
      mem_pos_y[wr_ptr] <= emit_pos_y;
      mem_pos_z[wr_ptr] <= emit_pos_z;
      mem_pos_w[wr_ptr] <= emit_pos_w;
      mem_norm_x[wr_ptr] <= emit_norm_x;
      mem_norm_y[wr_ptr] <= emit_norm_y;
      mem_norm_z[wr_ptr] <= emit_norm_z;
      mem_material[wr_ptr] <= emit_material;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      state <= S_IDLE;
      out_req <= 1'b0;
    end else begin
      // pointers wrap on their own since the depth is a power of two
      if (emit_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (emit_valid && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !emit_valid) begin
        count <= count - 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (count != '0) begin
            out_req <= 1'b1;
            state <= S_HOLD_REQ;
          end
        end
        S_HOLD_REQ: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state <= S_WAIT_RELEASE;
          end
        end
        default: begin
          if (!out_ack) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // head stays put until popped, so the fields are stable under req
  assign pos_x_out = mem_pos_x[rd_ptr];
  assign pos_y_out = mem_pos_y[rd_ptr];
  assign pos_z_out = mem_pos_z[rd_ptr];
  assign pos_w_out = mem_pos_w[rd_ptr];
  assign norm_x_out = mem_norm_x[rd_ptr];
  assign norm_y_out = mem_norm_y[rd_ptr];
  assign norm_z_out = mem_norm_z[rd_ptr];
  assign material_out = mem_material[rd_ptr];

endmodule

`default_nettype wire

// ==== hdl/clip_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module clip_stage_top #(
  parameter int QUEUE_DEPTH = 8
) (
  input wire clk_in,
  input wire rst_in,
  input wire in_req,
  output logic in_ack,
  input wire clip_pkg::fp32_t pos_x_in,
  input wire clip_pkg::fp32_t pos_y_in,
  input wire clip_pkg::fp32_t pos_z_in,
  input wire clip_pkg::fp32_t pos_w_in,
  input wire clip_pkg::fp32_t norm_x_in,
  input wire clip_pkg::fp32_t norm_y_in,
  input wire clip_pkg::fp32_t norm_z_in,
  input wire clip_pkg::material_t material_in,
  output logic out_req,
  input wire out_ack,
  output clip_pkg::fp32_t pos_x_out,
  output clip_pkg::fp32_t pos_y_out,
  output clip_pkg::fp32_t pos_z_out,
  output clip_pkg::fp32_t pos_w_out,
  output clip_pkg::fp32_t norm_x_out,
  output clip_pkg::fp32_t norm_y_out,
  output clip_pkg::fp32_t norm_z_out,
  output clip_pkg::material_t material_out
);

  import clip_pkg::*;

  // intake to clip
  logic vtx_valid;
  fp32_t pos_x, pos_y, pos_z, pos_w;
  fp32_t norm_x, norm_y, norm_z;
  material_t material;

  // clip to queue
  logic emit_valid;
  fp32_t emit_pos_x, emit_pos_y, emit_pos_z, emit_pos_w;
  fp32_t emit_norm_x, emit_norm_y, emit_norm_z;
  material_t emit_material;

  logic room;

  vertex_intake u_vertex_intake (
    .clk_in, .rst_in,
    .in_req, .in_ack,
    .pos_x_in, .pos_y_in, .pos_z_in, .pos_w_in,
    .norm_x_in, .norm_y_in, .norm_z_in, .material_in,
    .room,
    .vtx_valid,
    .pos_x, .pos_y, .pos_z, .pos_w,
    .norm_x, .norm_y, .norm_z, .material
  );

  triangle_clip u_triangle_clip (
    .clk_in, .rst_in,
    .vtx_valid,
    .pos_x, .pos_y, .pos_z, .pos_w,
    .norm_x, .norm_y, .norm_z, .material,
    .emit_valid,
    .emit_pos_x, .emit_pos_y, .emit_pos_z, .emit_pos_w,
    .emit_norm_x, .emit_norm_y, .emit_norm_z, .emit_material
  );

  vertex_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_vertex_queue (
    .clk_in, .rst_in,
    .emit_valid,
    .emit_pos_x, .emit_pos_y, .emit_pos_z, .emit_pos_w,
    .emit_norm_x, .emit_norm_y, .emit_norm_z, .emit_material,
    .room,
    .out_req, .out_ack,
    .pos_x_out, .pos_y_out, .pos_z_out, .pos_w_out,
    .norm_x_out, .norm_y_out, .norm_z_out, .material_out
  );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  // free-running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clip_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clip_stage;

  import clip_pkg::*;

  localparam int QUEUE_DEPTH = 8;
  // every vertex driven in, partial triangles included
  localparam int VERTS_SENT = 210;
  localparam int TIMEOUT_CYCLES = 300 * VERTS_SENT;

  localparam fp32_t POS_ZERO = 32'h0000_0000;
  localparam fp32_t NEG_ZERO = 32'h8000_0000;
  localparam fp32_t HALF = 32'h3f00_0000;
  localparam fp32_t NEG_HALF = 32'hbf00_0000;
  localparam fp32_t ONE = 32'h3f80_0000;
  localparam fp32_t NEG_ONE = 32'hbf80_0000;
  localparam fp32_t TWO = 32'h4000_0000;
  localparam fp32_t NEG_TWO = 32'hc000_0000;
  localparam fp32_t THREE = 32'h4040_0000;
  localparam fp32_t QNAN = 32'h7fc0_0000;
  // NaN whose magnitude bits sit above every other value
  localparam fp32_t NAN_MAX = 32'h7fff_ffff;

  typedef struct packed {
    fp32_t pos_x;
    fp32_t pos_y;
    fp32_t pos_z;
    fp32_t pos_w;
    fp32_t norm_x;
    fp32_t norm_y;
    fp32_t norm_z;
    material_t material;
  } vert_t;

  logic clk_in;
  logic rst_in;
  logic in_req;
  logic in_ack;
  fp32_t pos_x_in, pos_y_in, pos_z_in, pos_w_in;
  fp32_t norm_x_in, norm_y_in, norm_z_in;
  material_t material_in;
  logic out_req;
  logic out_ack;
  fp32_t pos_x_out, pos_y_out, pos_z_out, pos_w_out;
  fp32_t norm_x_out, norm_y_out, norm_z_out;
  material_t material_out;

  vert_t exp_q[$];
  integer seed = 32'h4d35_e50c;
  int cycles = 0;
  int ack_floor = 0;
  material_t mat_next = 12'h100;
  logic ack_prev = 1'b0;
  logic room_prev = 1'b1;
  logic room_fell = 1'b0;

  clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.clk(clk_in));

  clip_stage_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_clip_stage_top (
    .clk_in, .rst_in,
    .in_req, .in_ack,
    .pos_x_in, .pos_y_in, .pos_z_in, .pos_w_in,
    .norm_x_in, .norm_y_in, .norm_z_in, .material_in,
    .out_req, .out_ack,
    .pos_x_out, .pos_y_out, .pos_z_out, .pos_w_out,
    .norm_x_out, .norm_y_out, .norm_z_out, .material_out
  );

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_fp32(string name, fp32_t expected, fp32_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s expected %h got %h", $time, name, expected, actual);
      abort_run("output field mismatch");
    end
  endtask

  task automatic check_material(string name, material_t expected, material_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s expected %h got %h", $time, name, expected, actual);
      abort_run("output field mismatch");
    end
  endtask

  function automatic logic is_nan(fp32_t v);
    return (v[30:23] == 8'hff) && (v[22:0] != 23'd0);
  endfunction

  // inside when w is not negative, nothing is NaN and |a| <= |w|
  function automatic logic within_bound(fp32_t a, fp32_t w);
    logic w_neg;
    w_neg = w[31] && (w[30:0] != 31'd0);
    if (w_neg || is_nan(a) || is_nan(w)) begin
      return 1'b0;
    end
    return a[30:0] <= w[30:0];
  endfunction

  function automatic logic vertex_inside(vert_t v);
    return within_bound(v.pos_x, v.pos_w) && within_bound(v.pos_y, v.pos_w)
      && within_bound(v.pos_z, v.pos_w);
  endfunction

  function automatic logic triangle_kept(vert_t v0, vert_t v1, vert_t v2);
    return vertex_inside(v0) && vertex_inside(v1) && vertex_inside(v2);
  endfunction

  // random normals and a material that steps by an odd stride through all 12 bits
  function automatic vert_t make_vertex(fp32_t x, fp32_t y, fp32_t z, fp32_t w);
    vert_t v;
    v.pos_x = x;
    v.pos_y = y;
    v.pos_z = z;
    v.pos_w = w;
    v.norm_x = $random(seed);
    v.norm_y = $random(seed);
    v.norm_z = $random(seed);
    v.material = mat_next;
    mat_next = mat_next + 12'h9d3;
    return v;
  endfunction

  // wide lets the exponent reach one above w
  function automatic fp32_t rand_coord(fp32_t w, logic wide);
    logic [7:0] ex;
    if (wide) begin
      ex = w[30:23] - 8'd1 + 8'($unsigned($random(seed)) % 3);
    end else begin
      ex = w[30:23] - 8'd1 - 8'($unsigned($random(seed)) % 3);
    end
    return {1'($random(seed)), ex, 23'($random(seed))};
  endfunction

  function automatic fp32_t rand_w(logic allow_neg);
    logic neg;
    neg = allow_neg && (($unsigned($random(seed)) % 16) == 0);
    return {neg, 8'(126 + $unsigned($random(seed)) % 4), 23'($random(seed))};
  endfunction

  function automatic vert_t inside_vertex();
    fp32_t w;
    w = rand_w(1'b0);
    return make_vertex(rand_coord(w, 1'b0), rand_coord(w, 1'b0), rand_coord(w, 1'b0), w);
  endfunction

  task automatic apply_reset();
    @(posedge clk_in);
    rst_in <= 1'b1;
    repeat (10) @(posedge clk_in);
    rst_in <= 1'b0;
  endtask

  // four-phase sender, data settles one edge before req
  task automatic send_vertex(vert_t v);
    @(posedge clk_in);
    pos_x_in <= v.pos_x;
    pos_y_in <= v.pos_y;
    pos_z_in <= v.pos_z;
    pos_w_in <= v.pos_w;
    norm_x_in <= v.norm_x;
    norm_y_in <= v.norm_y;
    norm_z_in <= v.norm_z;
    material_in <= v.material;
    @(posedge clk_in);
    in_req <= 1'b1;
    @(negedge clk_in);
    while (!in_ack) @(negedge clk_in);
    @(posedge clk_in);
    in_req <= 1'b0;
    @(negedge clk_in);
    while (in_ack) @(negedge clk_in);
  endtask

  task automatic send_triangle(vert_t v0, vert_t v1, vert_t v2);
    if (triangle_kept(v0, v1, v2)) begin
      exp_q.push_back(v0);
      exp_q.push_back(v1);
      exp_q.push_back(v2);
    end
    send_vertex(v0);
    send_vertex(v1);
    send_vertex(v2);
  endtask

  task automatic send_random_triangle();
    vert_t v[3];
    fp32_t w;
    logic wide;
    for (int i = 0; i < 3; i++) begin
      w = rand_w(1'b1);
      wide = ($unsigned($random(seed)) % 6) == 0;
      v[i] = make_vertex(rand_coord(w, wide), rand_coord(w, 1'b0), rand_coord(w, 1'b0), w);
    end
    send_triangle(v[0], v[1], v[2]);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || out_req || out_ack) @(negedge clk_in);
  endtask

  task automatic expect_idle_output(int n);
    repeat (n) begin
      @(negedge clk_in);
      if (out_req) begin
        abort_run("out_req went high after reset with no full triangle sent");
      end
    end
  endtask

  // downstream side, random delay before each ack
  initial begin : acceptor
    int wait_cycles;
    out_ack <= 1'b0;
    forever begin
      @(negedge clk_in);
      if (!rst_in && out_req && !out_ack) begin
        wait_cycles = $unsigned($random(seed)) % 8;
        if (wait_cycles < ack_floor) begin
          wait_cycles = ack_floor;
        end
        repeat (wait_cycles) @(posedge clk_in);
        @(posedge clk_in);
        out_ack <= 1'b1;
        @(negedge clk_in);
        while (out_req) @(negedge clk_in);
        @(posedge clk_in);
        out_ack <= 1'b0;
      end
    end
  end

  // req and ack are both high on exactly one falling edge per vertex
  always @(negedge clk_in) begin : compare_output
    vert_t exp_v;
    if (!rst_in && out_req && out_ack) begin
      if (exp_q.size() == 0) begin
        abort_run("a vertex came out that no kept triangle accounts for");
      end else begin
        exp_v = exp_q.pop_front();
        check_fp32("pos_x_out", exp_v.pos_x, pos_x_out);
        check_fp32("pos_y_out", exp_v.pos_y, pos_y_out);
        check_fp32("pos_z_out", exp_v.pos_z, pos_z_out);
        check_fp32("pos_w_out", exp_v.pos_w, pos_w_out);
        check_fp32("norm_x_out", exp_v.norm_x, norm_x_out);
        check_fp32("norm_y_out", exp_v.norm_y, norm_y_out);
        check_fp32("norm_z_out", exp_v.norm_z, norm_z_out);
        check_material("material_out", exp_v.material, material_out);
      end
    end
  end

  // a new in_ack needs room in the cycle that decided it
  always @(negedge clk_in) begin : room_monitor
    if (!rst_in && in_ack && !ack_prev && !room_prev) begin
      abort_run("in_ack rose while the vertex queue had no room for a triangle");
    end
    if (!rst_in && !u_clip_stage_top.room) begin
      room_fell = 1'b1;
    end
    ack_prev = in_ack;
    room_prev = u_clip_stage_top.room;
  end

  always @(posedge clk_in) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run("timeout, the DUT stopped answering the handshakes");
    end
  end

  initial begin : stimulus
    vert_t a;
    vert_t b;
    vert_t c;
    rst_in <= 1'b1;
    in_req <= 1'b0;
    pos_x_in <= '0;
    pos_y_in <= '0;
    pos_z_in <= '0;
    pos_w_in <= '0;
    norm_x_in <= '0;
    norm_y_in <= '0;
    norm_z_in <= '0;
    material_in <= '0;
    apply_reset();

    // plain triangle, all inside
    a = make_vertex(HALF, NEG_HALF, POS_ZERO, ONE);
    b = make_vertex(NEG_ONE, ONE, HALF, TWO);
    c = make_vertex(POS_ZERO, HALF, NEG_HALF, HALF);
    send_triangle(a, b, c);

    // one z outside, then a good one
    a = make_vertex(HALF, HALF, HALF, ONE);
    b = make_vertex(HALF, HALF, THREE, ONE);
    c = make_vertex(HALF, HALF, HALF, ONE);
    send_triangle(a, b, c);
    send_triangle(inside_vertex(), inside_vertex(), inside_vertex());

    // edges of the bound
    a = make_vertex(TWO, NEG_TWO, TWO, TWO);
    b = make_vertex(NEG_ONE, ONE, NEG_ONE, ONE);
    c = make_vertex(HALF, HALF, NEG_HALF, HALF);
    send_triangle(a, b, c);
    a = make_vertex(NEG_ZERO, POS_ZERO, NEG_ZERO, POS_ZERO);
    b = make_vertex(POS_ZERO, NEG_ZERO, POS_ZERO, POS_ZERO);
    c = make_vertex(NEG_ZERO, NEG_ZERO, NEG_ZERO, POS_ZERO);
    send_triangle(a, b, c);
    a = make_vertex(HALF, HALF, HALF, ONE);
    b = make_vertex(POS_ZERO, POS_ZERO, POS_ZERO, NEG_ONE);
    send_triangle(a, b, inside_vertex());
    c = make_vertex(QNAN, HALF, HALF, ONE);
    send_triangle(inside_vertex(), inside_vertex(), c);
    // magnitudes all fit, only the NaN w rejects
    c = make_vertex(HALF, NEG_HALF, HALF, NAN_MAX);
    send_triangle(c, inside_vertex(), inside_vertex());

    // slow downstream so the queue fills up
    ack_floor = 4;
    repeat (20) send_triangle(inside_vertex(), inside_vertex(), inside_vertex());
    wait_drained();
    ack_floor = 0;
    if (!room_fell) begin
      abort_run("the vertex queue never filled under back-pressure");
    end

    // partial triangles cut by reset
    send_vertex(inside_vertex());
    apply_reset();
    expect_idle_output(20);
    send_vertex(inside_vertex());
    send_vertex(inside_vertex());
    apply_reset();
    expect_idle_output(20);
    send_triangle(inside_vertex(), inside_vertex(), inside_vertex());

    repeat (40) send_random_triangle();

    wait_drained();
    repeat (20) @(negedge clk_in);
    if (exp_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("expected vertices never came out");
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
common/clip_pkg.sv
hdl/fp32_bound.sv
hdl/vertex_intake.sv
clip/triangle_clip.sv
hdl/vertex_queue.sv
hdl/clip_stage_top.sv
bench/clk_gen.sv
bench/tb_clip_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the clip stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_clip_stage -f tb.f -o sim_clip \
  > sim.log 2>&1 && ./obj_dir/sim_clip >> sim.log 2>&1 || echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
